//--- axi4_burst_responder.f
hdl/axi4_resp_pkg.sv
hdl/channel_slice.sv
hdl/write_responder.sv
hdl/read_burst_gen.sv
hdl/axi4_burst_responder.sv
verification/tb_clock_gen.sv
verification/axi4_burst_responder_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the axi4_burst_responder testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=axi4_burst_responder_tb
build_dir=obj_dir

echo "Building ${top}"
verilator --binary --timing --assert \
   --top-module "${top}" \
   -f axi4_burst_responder.f \
   --Mdir "${build_dir}" \
   -o "${top}"
status=$?
if [ ${status} -ne 0 ]; then
   echo "Verilator build failed with status ${status}"
   exit ${status}
fi

echo "Running ${top}"
"./${build_dir}/${top}"
status=$?
if [ ${status} -ne 0 ]; then
   echo "Simulation failed with status ${status}"
   exit ${status}
fi

echo "Simulation finished cleanly"
exit 0

//--- verification/axi4_burst_responder_tb.sv
// AXI4 burst responder testbench with random read and write bursts and a queued reference model
`timescale 1ns/1ps
`default_nettype none

module axi4_burst_responder_tb;

   import axi4_resp_pkg::*;

   localparam int n_reads  = 24;
   localparam int n_writes = 24;

   // DUT ports
   logic                  aclk;
   logic                  rst;
   logic                  awvalid;
   logic                  awready;
   logic [AXI_ID_W-1:0]   awid;
   logic [AXI_LEN_W-1:0]  awlen;
   logic                  wvalid;
   logic                  wready;
   logic                  wlast;
   logic                  bvalid;
   logic                  bready;
   logic [AXI_ID_W-1:0]   bid;
   logic                  arvalid;
   logic                  arready;
   logic [AXI_ID_W-1:0]   arid;
   logic [AXI_LEN_W-1:0]  arlen;
   logic                  rvalid;
   logic                  rready;
   logic [AXI_ID_W-1:0]   rid;
   logic [AXI_DATA_W-1:0] rdata;
   logic                  rlast;

   // Stimulus tables filled at time zero
   int rd_id  [n_reads];
   int rd_len [n_reads];
   bit rd_gap [n_reads];
   int wr_id  [n_writes];
   int wr_len [n_writes];
   bit wr_gap [n_writes];
   // Expectations in request order
   int rd_id_q[$];
   int rd_len_q[$];
   int wr_id_q[$];
   // Progress and bookkeeping
   int          rd_done     = 0;
   int          wr_done     = 0;
   int          r_beat_idx  = 0;
   int          cycle_count = 0;
   int          cycle_limit = 1000;
   bit          start_traffic = 1'b0;
   bit          r_stalled   = 1'b0;
   bit          b_stalled   = 1'b0;
   r_beat_t     r_held;
   logic [AXI_ID_W-1:0] b_held;
   logic [31:0] lfsr_state  = 32'd88292;

   tb_clock_gen #(.reset_cycles(10)) tb_clock_gen_i (.aclk(aclk), .rst(rst));

   axi4_burst_responder axi4_burst_responder_i (.*);

   //////////////////////////////////////////////////////////////////////
   // Random source and reference model
   //////////////////////////////////////////////////////////////////////
   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One step per bit taken
   function automatic int rand_bits(input int n);
      int r;
      r = 0;
      for (int k = 0; k < n; k++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         r = (r << 1) | int'(lfsr_state[0]);
      end
      return r;
   endfunction

   // Beat idx of a burst counts up from 0 with last only on beat len
   function automatic r_beat_t expected_beat(input int id, input int len, input int idx);
      r_beat_t e;
      e.id   = AXI_ID_W'(id);
      e.data = AXI_DATA_W'(idx);
      e.last = (idx == len);
      return e;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
         $display("FAIL: see errors above");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic stop_run(input string why);
      $display("ERROR: %s", why);
      $display("FAIL: see errors above");
      $fatal(1, "%s", why);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////
   initial
   begin
      int total;
      total = 0;
      // Lengths 0 to 15 with a gap before about one request in four
      for (int i = 0; i < n_reads; i++)
      begin
         rd_id[i]  = rand_bits(4);
         rd_len[i] = rand_bits(4);
         rd_gap[i] = (rand_bits(2) == 0);
         total += rd_len[i] + 1;
      end
      for (int i = 0; i < n_writes; i++)
      begin
         wr_id[i]  = rand_bits(4);
         wr_len[i] = rand_bits(4);
         wr_gap[i] = (rand_bits(2) == 0);
         total += wr_len[i] + 1;
      end
      cycle_limit = 4 * total + 200;
      // No response valid while in reset
      repeat (2) @(posedge aclk);
      while (rst)
      begin
         check_value("bvalid", 64'(bvalid), 64'(0));
         check_value("rvalid", 64'(rvalid), 64'(0));
         @(posedge aclk);
      end
      // Idle after reset with nothing requested yet
      repeat (4)
      begin
         check_value("bvalid", 64'(bvalid), 64'(0));
         check_value("rvalid", 64'(rvalid), 64'(0));
         check_value("wready", 64'(wready), 64'(0));
         check_value("awready", 64'(awready), 64'(1));
         check_value("arready", 64'(arready), 64'(1));
         @(posedge aclk);
      end
      start_traffic = 1'b1;
      while (rd_done < n_reads || wr_done < n_writes)
         @(posedge aclk);
      // Quiet window so an extra beat or response shows up in the monitors
      repeat (20) @(posedge aclk);
      // Back to idle once every burst has completed
      if (bvalid || rvalid || wready || !awready || !arready)
         stop_run("DUT did not return to idle after all bursts completed");
      else
      begin
         $display("PASS: all tests");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Drivers on the falling edge
   //////////////////////////////////////////////////////////////////////
   // Read requests
   initial
   begin
      arvalid = 1'b0;
      arid    = '0;
      arlen   = '0;
      wait (start_traffic);
      for (int i = 0; i < n_reads; i++)
      begin
         @(negedge aclk);
         if (rd_gap[i])
         begin
            arvalid = 1'b0;
            @(negedge aclk);
         end
         arvalid = 1'b1;
         arid    = AXI_ID_W'(rd_id[i]);
         arlen   = AXI_LEN_W'(rd_len[i]);
         @(posedge aclk);
         while (!arready)
            @(posedge aclk);
         rd_id_q.push_back(rd_id[i]);
         rd_len_q.push_back(rd_len[i]);
      end
      @(negedge aclk);
      arvalid = 1'b0;
   end

   // Write address then its data burst
   initial
   begin
      awvalid = 1'b0;
      awid    = '0;
      awlen   = '0;
      wvalid  = 1'b0;
      wlast   = 1'b0;
      wait (start_traffic);
      for (int i = 0; i < n_writes; i++)
      begin
         @(negedge aclk);
         wvalid = 1'b0;
         wlast  = 1'b0;
         if (wr_gap[i])
            @(negedge aclk);
         awvalid = 1'b1;
         awid    = AXI_ID_W'(wr_id[i]);
         awlen   = AXI_LEN_W'(wr_len[i]);
         @(posedge aclk);
         while (!awready)
            @(posedge aclk);
         for (int b = 0; b <= wr_len[i]; b++)
         begin
            @(negedge aclk);
            awvalid = 1'b0;
            wvalid  = 1'b1;
            wlast   = (b == wr_len[i]);
            @(posedge aclk);
            while (!wready)
               @(posedge aclk);
         end
         // B legal only from here on
         wr_id_q.push_back(wr_id[i]);
      end
      @(negedge aclk);
      wvalid = 1'b0;
      wlast  = 1'b0;
   end

   // Back-pressure with each ready low about one cycle in four
   initial
   begin
      rready = 1'b1;
      bready = 1'b1;
      forever
      begin
         @(negedge aclk);
         if (!rst && start_traffic)
         begin
            rready = (rand_bits(2) != 0);
            bready = (rand_bits(2) != 0);
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Monitors and timeout
   //////////////////////////////////////////////////////////////////////
   // R channel against the reference beat
   always @(posedge aclk)
   begin
      r_beat_t got;
      r_beat_t exp;
      got.id   = rid;
      got.data = rdata;
      got.last = rlast;
      if (!rst)
      begin
         // Stalled beat held unchanged
         if (r_stalled)
         begin
            check_value("rvalid", 64'(rvalid), 64'(1));
            check_value("rid", 64'(got.id), 64'(r_held.id));
            check_value("rdata", 64'(got.data), 64'(r_held.data));
            check_value("rlast", 64'(got.last), 64'(r_held.last));
         end
         if (rvalid && rready)
         begin
            if (rd_id_q.size() == 0)
               stop_run("read beat returned with no outstanding read request");
            else
            begin
               exp = expected_beat(rd_id_q[0], rd_len_q[0], r_beat_idx);
               check_value("rid", 64'(got.id), 64'(exp.id));
               check_value("rdata", 64'(got.data), 64'(exp.data));
               check_value("rlast", 64'(got.last), 64'(exp.last));
               if (exp.last)
               begin
                  void'(rd_id_q.pop_front());
                  void'(rd_len_q.pop_front());
                  r_beat_idx = 0;
                  rd_done++;
               end
               else
                  r_beat_idx++;
            end
         end
         r_stalled = rvalid && !rready;
         r_held    = got;
      end
   end

   // B channel expects one response per completed burst in order
   always @(posedge aclk)
   begin
      int exp_id;
      if (!rst)
      begin
         if (b_stalled)
         begin
            check_value("bvalid", 64'(bvalid), 64'(1));
            check_value("bid", 64'(bid), 64'(b_held));
         end
         if (bvalid && bready)
         begin
            if (wr_id_q.size() == 0)
               stop_run("write response arrived with no completed write burst");
            else
            begin
               exp_id = wr_id_q.pop_front();
               check_value("bid", 64'(bid), 64'(exp_id));
               wr_done++;
            end
         end
         b_stalled = bvalid && !bready;
         b_held    = bid;
      end
   end

   // Cycle limit from total beats issued
   always @(posedge aclk)
   begin
      if (!rst)
      begin
         cycle_count++;
         if (cycle_count > cycle_limit)
            stop_run($sformatf("timeout after %0d cycles with responses outstanding",
                               cycle_count));
      end
   end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// tb_clock_gen: free-running aclk and a synchronous reset pulse for the testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int reset_cycles = 10
) (
   output logic aclk,
   output logic rst
);

   // 4 ns period
   initial
   begin
      aclk = 1'b0;
      forever #2 aclk = ~aclk;
   end

   // Reset held for whole cycles, released on a falling edge
   initial
   begin
      rst = 1'b1;
      repeat (reset_cycles) @(posedge aclk);
      @(negedge aclk);
      rst = 1'b0;
   end

endmodule

`default_nettype wire

//--- hdl/axi4_burst_responder.sv
// axi4_burst_responder: AXI4 slave answering write and read bursts through registered channels
`timescale 1ns/1ps
`default_nettype none

module axi4_burst_responder (
   input  wire logic                                 aclk,
   input  wire logic                                 rst,
   // Write address
   input  wire logic                                 awvalid,
   output logic                                      awready,
   input  wire logic [axi4_resp_pkg::AXI_ID_W-1:0]   awid,
   input  wire logic [axi4_resp_pkg::AXI_LEN_W-1:0]  awlen,
   // Write data
   input  wire logic                                 wvalid,
   output logic                                      wready,
   input  wire logic                                 wlast,
   // Write response
   output logic                                      bvalid,
   input  wire logic                                 bready,
   output logic [axi4_resp_pkg::AXI_ID_W-1:0]        bid,
   // Read address
   input  wire logic                                 arvalid,
   output logic                                      arready,
   input  wire logic [axi4_resp_pkg::AXI_ID_W-1:0]   arid,
   input  wire logic [axi4_resp_pkg::AXI_LEN_W-1:0]  arlen,
   // Read data
   output logic                                      rvalid,
   input  wire logic                                 rready,
   output logic [axi4_resp_pkg::AXI_ID_W-1:0]        rid,
   output logic [axi4_resp_pkg::AXI_DATA_W-1:0]      rdata,
   output logic                                      rlast
);

   //////////////////////////////////////////////////////////////////////
   // Channel payloads
   //////////////////////////////////////////////////////////////////////
   axi4_resp_pkg::aw_req_t aw_in, aw_out;
   axi4_resp_pkg::w_beat_t w_in, w_out;
   axi4_resp_pkg::b_resp_t b_in, b_out;
   axi4_resp_pkg::ar_req_t ar_in, ar_out;
   axi4_resp_pkg::r_beat_t r_in, r_out;
   // Slice to responder handshakes
   logic aw_out_valid, aw_out_ready;
   logic w_in_valid, w_in_ready, w_out_valid, w_out_ready;
   logic b_in_valid, b_in_ready;
   logic ar_out_valid, ar_out_ready;
   logic r_in_valid, r_in_ready;
   // Write address present downstream
   logic w_open;

   // Pack inbound fields, awlen unused since bursts end on wlast
   assign aw_in.id  = awid;
   assign w_in.last = wlast;
   assign ar_in.id  = arid;
   assign ar_in.len = arlen;
   // Unpack outbound fields
   assign bid   = b_out.id;
   assign rid   = r_out.id;
   assign rdata = r_out.data;
   assign rlast = r_out.last;

   // W held off until an address sits in the AW slice or the responder
   assign w_open     = aw_out_valid || !aw_out_ready;
   assign wready     = w_in_ready && w_open;
   assign w_in_valid = wvalid && w_open;

   //////////////////////////////////////////////////////////////////////
   // Write path
   //////////////////////////////////////////////////////////////////////
   channel_slice #(.payload_t(axi4_resp_pkg::aw_req_t)) aw_slice_i (
      .aclk(aclk), .rst(rst),
      .in_valid(awvalid), .in_ready(awready), .in_payload(aw_in),
      .out_valid(aw_out_valid), .out_ready(aw_out_ready), .out_payload(aw_out));

   channel_slice #(.payload_t(axi4_resp_pkg::w_beat_t)) w_slice_i (
      .aclk(aclk), .rst(rst),
      .in_valid(w_in_valid), .in_ready(w_in_ready), .in_payload(w_in),
      .out_valid(w_out_valid), .out_ready(w_out_ready), .out_payload(w_out));

   write_responder write_responder_i (
      .aclk(aclk), .rst(rst),
      .aw_valid(aw_out_valid), .aw_ready(aw_out_ready), .aw_req(aw_out),
      .w_valid(w_out_valid), .w_ready(w_out_ready), .w_beat(w_out),
      .b_valid(b_in_valid), .b_ready(b_in_ready), .b_resp(b_in));

   channel_slice #(.payload_t(axi4_resp_pkg::b_resp_t)) b_slice_i (
      .aclk(aclk), .rst(rst),
      .in_valid(b_in_valid), .in_ready(b_in_ready), .in_payload(b_in),
      .out_valid(bvalid), .out_ready(bready), .out_payload(b_out));

   //////////////////////////////////////////////////////////////////////
   // Read path
   //////////////////////////////////////////////////////////////////////
   channel_slice #(.payload_t(axi4_resp_pkg::ar_req_t)) ar_slice_i (
      .aclk(aclk), .rst(rst),
      .in_valid(arvalid), .in_ready(arready), .in_payload(ar_in),
      .out_valid(ar_out_valid), .out_ready(ar_out_ready), .out_payload(ar_out));

   read_burst_gen read_burst_gen_i (
      .aclk(aclk), .rst(rst),
      .ar_valid(ar_out_valid), .ar_ready(ar_out_ready), .ar_req(ar_out),
      .r_valid(r_in_valid), .r_ready(r_in_ready), .r_beat(r_in));

   channel_slice #(.payload_t(axi4_resp_pkg::r_beat_t)) r_slice_i (
      .aclk(aclk), .rst(rst),
      .in_valid(r_in_valid), .in_ready(r_in_ready), .in_payload(r_in),
      .out_valid(rvalid), .out_ready(rready), .out_payload(r_out));

endmodule

`default_nettype wire

//--- hdl/read_burst_gen.sv
// read_burst_gen: expands one read address into a counted burst of read data beats
`timescale 1ns/1ps
`default_nettype none

module read_burst_gen (
   input  wire logic                    aclk,
   input  wire logic                    rst,
   // Read address
   input  wire logic                    ar_valid,
   output logic                         ar_ready,
   input  wire axi4_resp_pkg::ar_req_t  ar_req,
   // Read data
   output logic                         r_valid,
   input  wire logic                    r_ready,
   output axi4_resp_pkg::r_beat_t       r_beat
);

   import axi4_resp_pkg::*;

   //////////////////////////////////////////////////////////////////////
   // Burst state
   //////////////////////////////////////////////////////////////////////
   // Captured request
   logic [AXI_ID_W-1:0]  id_q;
   logic [AXI_LEN_W-1:0] len_q;
   // Beat index within the burst
   logic [AXI_LEN_W-1:0] cnt;
   // Handshakes
   logic                 ar_fire;
   logic                 r_fire;
   logic                 r_last;

   assign r_last   = (cnt == len_q);
   assign r_fire   = r_valid && r_ready;
   // Next address overlaps the final beat
   assign ar_ready = !r_valid || (r_fire && r_last);
   assign ar_fire  = ar_valid && ar_ready;

   // Beat built from registers only, so it holds under stall
   assign r_beat.id   = id_q;
   assign r_beat.data = AXI_DATA_W'(cnt);
   assign r_beat.last = r_last;

   //////////////////////////////////////////////////////////////////////
   // Counter and valid
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge aclk)
   begin
      if (rst)
      begin
         r_valid <= 1'b0;
         cnt     <= '0;
      end
      else if (ar_fire)
      begin
         // First beat goes out next cycle
         r_valid <= 1'b1;
         cnt     <= '0;
      end
      else if (r_fire)
      begin
         if (r_last)
         begin
            r_valid <= 1'b0;
            cnt     <= '0;
         end
         else
            cnt <= cnt + 1'b1;
      end
   end

   // Request capture
   always_ff @(posedge aclk)
   begin
      if (ar_fire)
      begin
         id_q  <= ar_req.id;
         len_q <= ar_req.len;
      end
   end

   // A non-final beat is always followed by one still inside the length
   cnt_in_range_a : assert property (@(posedge aclk) disable iff (rst)
      r_valid && !r_last |=> r_valid && (cnt <= len_q));

endmodule

`default_nettype wire

//--- hdl/write_responder.sv
// Write responder that pairs each write address with its data burst and returns one response
`timescale 1ns/1ps
`default_nettype none

module write_responder (
   input  wire logic                    aclk,
   input  wire logic                    rst,
   // Write address
   input  wire logic                    aw_valid,
   output logic                         aw_ready,
   input  wire axi4_resp_pkg::aw_req_t  aw_req,
   // Write data
   input  wire logic                    w_valid,
   output logic                         w_ready,
   input  wire axi4_resp_pkg::w_beat_t  w_beat,
   // Write response
   output logic                         b_valid,
   input  wire logic                    b_ready,
   output axi4_resp_pkg::b_resp_t       b_resp
);

   import axi4_resp_pkg::*;

   // Address currently owning the W channel
   logic                aw_held;
   logic [AXI_ID_W-1:0] held_id;
   // Handshakes
   logic                aw_fire;
   logic                w_fire;
   logic                b_fire;

   assign b_fire   = b_valid && b_ready;
   // Held address retires with its B so a new one may enter the same cycle
   assign aw_ready = !aw_held || b_fire;
   assign aw_fire  = aw_valid && aw_ready;
   // Data only while an address is held and no B is waiting
   assign w_ready  = aw_held && !b_valid;
   assign w_fire   = w_valid && w_ready;

   //////////////////////////////////////////////////////////////////////
   // Control
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge aclk)
   begin
      if (rst)
      begin
         aw_held <= 1'b0;
         b_valid <= 1'b0;
      end
      else
      begin
         if (aw_fire)
            aw_held <= 1'b1;
         else if (b_fire)
            aw_held <= 1'b0;
         // Burst ends on wlast and awlen plays no part
         if (w_fire && w_beat.last)
            b_valid <= 1'b1;
         else if (b_fire)
            b_valid <= 1'b0;
      end
   end

   // Id capture and registered response
   always_ff @(posedge aclk)
   begin
      if (aw_fire)
         held_id <= aw_req.id;
      if (w_fire && w_beat.last)
         b_resp.id <= held_id;
   end

   // Pending response neither dropped nor overwritten by a later data beat
   b_stable_a : assert property (@(posedge aclk) disable iff (rst)
      b_valid && !b_ready |=> b_valid && $stable(b_resp));

endmodule

`default_nettype wire

//--- hdl/channel_slice.sv
// channel_slice: two-entry valid/ready register slice for an arbitrary payload type
`timescale 1ns/1ps
`default_nettype none

module channel_slice #(
   parameter type payload_t = logic
) (
   input  wire logic aclk,
   input  wire logic rst,
   // Upstream side
   input  wire logic in_valid,
   output logic      in_ready,
   input  wire       payload_t in_payload,
   // Downstream side
   output logic      out_valid,
   input  wire logic out_ready,
   output payload_t  out_payload
);

   //////////////////////////////////////////////////////////////////////
   // Storage
   //////////////////////////////////////////////////////////////////////
   // Skid entry, filled only when output is stalled
   logic     skid_valid;
   payload_t skid_payload;
   // Output entry free or draining this cycle
   logic     load_out;

   assign load_out = out_ready || !out_valid;

   // Ready from own occupancy only, no path from out_ready
   assign in_ready = !skid_valid;

   //////////////////////////////////////////////////////////////////////
   // Control
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge aclk)
   begin
      if (rst)
      begin
         out_valid  <= 1'b0;
         skid_valid <= 1'b0;
      end
      else if (load_out)
      begin
         // Skid drains first to keep order
         if (skid_valid)
         begin
            out_valid  <= 1'b1;
            skid_valid <= 1'b0;
         end
         else
            out_valid <= in_valid;
      end
      else if (in_valid && in_ready)
         skid_valid <= 1'b1;
   end

   // Payload path
   always_ff @(posedge aclk)
   begin
      if (load_out)
      begin
         if (skid_valid)
            out_payload <= skid_payload;
         else if (in_valid)
            out_payload <= in_payload;
      end
      // Catch the beat that arrives under a stall
      if (!load_out && in_valid && in_ready)
         skid_payload <= in_payload;
   end

   // Stalled output holds valid and payload
   stall_stable_a : assert property (@(posedge aclk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_payload));

endmodule

`default_nettype wire

//--- hdl/axi4_resp_pkg.sv
// axi4_resp_pkg: AXI field widths and channel payload structs for the burst responder
`default_nettype none

package axi4_resp_pkg;

   //////////////////////////////////////////////////////////////////////
   // Field widths
   //////////////////////////////////////////////////////////////////////
   // Transaction id
   localparam int AXI_ID_W   = 4;
   // Burst length, fixed at 8 bits by AXI4
   localparam int AXI_LEN_W  = 8;
   // One read data word
   localparam int AXI_DATA_W = 32;

   //////////////////////////////////////////////////////////////////////
   // Channel payloads
   //////////////////////////////////////////////////////////////////////
   // Write address, id only
   typedef struct packed {
      logic [AXI_ID_W-1:0] id;
   } aw_req_t;

   // Write data, only the last flag survives
   typedef struct packed {
      logic last;
   } w_beat_t;

   // Write response, always OKAY
   typedef struct packed {
      logic [AXI_ID_W-1:0] id;
   } b_resp_t;

   // Read address
   typedef struct packed {
      logic [AXI_ID_W-1:0]  id;
      logic [AXI_LEN_W-1:0] len;
   } ar_req_t;

   // Read data beat
   typedef struct packed {
      logic [AXI_ID_W-1:0]   id;
      logic [AXI_DATA_W-1:0] data;
      logic                  last;
   } r_beat_t;

endpackage

`default_nettype wire
